/* dma_ctrl_pkg.sv */
`default_nettype none

package dma_ctrl_pkg;

    // bus and descriptor widths
    localparam int axil_addr_width    = 32;
    localparam int axil_data_width    = 32;
    localparam int decode_addr_width  = 16;
    localparam int pcie_addr_width    = 64;
    localparam int dma_axi_addr_width = 32;
    localparam int dma_len_width      = 16;
    localparam int dma_tag_width      = 8;
    localparam int count_width        = 32;

    // register index inside a channel block, address bits 4:2
    localparam int chan_reg_width = 3;

    // block base addresses
    localparam logic [15:0] addr_enable     = 16'h0000;
    localparam logic [15:0] addr_read_chan  = 16'h0100;
    localparam logic [15:0] addr_write_chan = 16'h0200;
    localparam logic [15:0] addr_counters   = 16'h0400;

    // channel register offsets
    localparam logic [4:0] chan_pcie_addr_lo = 5'h00;
    localparam logic [4:0] chan_pcie_addr_hi = 5'h04;
    localparam logic [4:0] chan_axi_addr     = 5'h08;
    localparam logic [4:0] chan_len          = 5'h10;
    localparam logic [4:0] chan_tag_go       = 5'h14;
    localparam logic [4:0] chan_status       = 5'h18;

    // frame counter offsets
    localparam logic [3:0] off_rq = 4'h0;
    localparam logic [3:0] off_rc = 4'h4;
    localparam logic [3:0] off_cq = 4'h8;
    localparam logic [3:0] off_cc = 4'hc;

    localparam int status_valid_bit = 31;

    localparam logic [1:0] resp_okay = 2'b00;

endpackage

`default_nettype wire

/* axil_reg_port.sv */
`default_nettype none

module axil_reg_port (
    input  wire                                        clk,
    input  wire                                        rst,
    input  wire  [dma_ctrl_pkg::axil_addr_width-1:0]   awaddr,
    input  wire                                        awvalid,
    output logic                                       awready,
    input  wire  [dma_ctrl_pkg::axil_data_width-1:0]   wdata,
    input  wire  [dma_ctrl_pkg::axil_data_width/8-1:0] wstrb,
    input  wire                                        wvalid,
    output logic                                       wready,
    output logic [1:0]                                 bresp,
    output logic                                       bvalid,
    input  wire                                        bready,
    input  wire  [dma_ctrl_pkg::axil_addr_width-1:0]   araddr,
    input  wire                                        arvalid,
    output logic                                       arready,
    output logic [dma_ctrl_pkg::axil_data_width-1:0]   rdata,
    output logic [1:0]                                 rresp,
    output logic                                       rvalid,
    input  wire                                        rready,
    output logic                                       wr_en,
    output logic [dma_ctrl_pkg::axil_addr_width-1:0]   wr_addr,
    output logic [dma_ctrl_pkg::axil_data_width-1:0]   wr_data,
    output logic                                       rd_en,
    output logic [dma_ctrl_pkg::axil_addr_width-1:0]   rd_addr,
    input  wire  [dma_ctrl_pkg::axil_data_width-1:0]   rd_data
);
    import dma_ctrl_pkg::*;

    // full-word registers only, wstrb is not looked at
    // a pending response blocks the next access on that side
    assign wr_en   = awvalid && wvalid && !bvalid;
    assign wr_addr = awaddr;
    assign wr_data = wdata;
    assign rd_en   = arvalid && !rvalid;
    assign rd_addr = araddr;

    always_ff @(posedge clk) begin
        if (rst) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            awready <= wr_en;
            wready  <= wr_en;
            bvalid  <= wr_en || (bvalid && !bready);
            arready <= rd_en;
            rvalid  <= rd_en || (rvalid && !rready);
        end
    end

    // response payload
    always_ff @(posedge clk) begin
        if (wr_en)
            bresp <= resp_okay;
        if (rd_en) begin
            rdata <= rd_data;
            rresp <= resp_okay;
        end
    end

    assert property (@(posedge clk) disable iff (rst) bvalid && !bready |=> bvalid);
    assert property (@(posedge clk) disable iff (rst) rvalid && !rready |=> rvalid);

endmodule

`default_nettype wire

/* ctrl_reg_map.sv */
`default_nettype none

module ctrl_reg_map (
    input  wire                                      clk,
    input  wire                                      rst,
    input  wire                                      wr_en,
    input  wire  [dma_ctrl_pkg::axil_addr_width-1:0] wr_addr,
    input  wire  [dma_ctrl_pkg::axil_data_width-1:0] wr_data,
    input  wire                                      rd_en,
    input  wire  [dma_ctrl_pkg::axil_addr_width-1:0] rd_addr,
    output logic [dma_ctrl_pkg::axil_data_width-1:0] rd_data,
    output logic                                     read_chan_wr,
    output logic                                     write_chan_wr,
    output logic                                     read_chan_rd,
    output logic                                     write_chan_rd,
    output logic [dma_ctrl_pkg::chan_reg_width-1:0]  wr_reg,
    input  wire  [dma_ctrl_pkg::axil_data_width-1:0] read_rd_word,
    input  wire  [dma_ctrl_pkg::axil_data_width-1:0] write_rd_word,
    input  wire  [dma_ctrl_pkg::count_width-1:0]     rq_count,
    input  wire  [dma_ctrl_pkg::count_width-1:0]     rc_count,
    input  wire  [dma_ctrl_pkg::count_width-1:0]     cq_count,
    input  wire  [dma_ctrl_pkg::count_width-1:0]     cc_count,
    input  wire                                      read_status_valid,
    input  wire                                      write_status_valid,
    output logic                                     dma_enable,
    output logic                                     irq
);
    import dma_ctrl_pkg::*;

    logic [decode_addr_width-1:0] wa;
    logic [decode_addr_width-1:0] ra;
    logic                         enable_wr;

    // true when an address falls in the 32-byte block at base
    function automatic logic in_chan(input logic [decode_addr_width-1:0] a,
                                     input logic [decode_addr_width-1:0] base);
        return a[decode_addr_width-1:5] == base[decode_addr_width-1:5];
    endfunction

    // byte lanes dropped
    assign wa = {wr_addr[decode_addr_width-1:2], 2'b00};
    assign ra = {rd_addr[decode_addr_width-1:2], 2'b00};

    assign enable_wr     = wr_en && wa == addr_enable;
    assign read_chan_wr  = wr_en && in_chan(wa, addr_read_chan);
    assign write_chan_wr = wr_en && in_chan(wa, addr_write_chan);
    assign wr_reg        = wa[chan_reg_width+1:2];

    // only the status register has a read side effect
    assign read_chan_rd  = rd_en && in_chan(ra, addr_read_chan) && ra[4:0] == chan_status;
    assign write_chan_rd = rd_en && in_chan(ra, addr_write_chan) && ra[4:0] == chan_status;

    assign irq = read_status_valid || write_status_valid;

    always_ff @(posedge clk) begin
        if (rst)
            dma_enable <= 1'b0;
        else if (enable_wr)
            dma_enable <= wr_data[0];
    end

    always_comb begin
        rd_data = '0;
        if (ra == addr_enable) begin
            rd_data[0] = dma_enable;
        end else if (in_chan(ra, addr_read_chan)) begin
            rd_data = read_rd_word;
        end else if (in_chan(ra, addr_write_chan)) begin
            rd_data = write_rd_word;
        end else if (ra[decode_addr_width-1:4] == addr_counters[decode_addr_width-1:4]) begin
            case (ra[3:0])
                off_rq:  rd_data = rq_count;
                off_rc:  rd_data = rc_count;
                off_cq:  rd_data = cq_count;
                off_cc:  rd_data = cc_count;
                default: rd_data = '0;
            endcase
        end
    end

    // each access lands in one block at most
    assert property (@(posedge clk) disable iff (rst)
        $onehot0({enable_wr, read_chan_wr, write_chan_wr})
        && $onehot0({read_chan_rd, write_chan_rd}));

endmodule

`default_nettype wire

/* dma_desc_regs.sv */
`default_nettype none

module dma_desc_regs (
    input  wire                                         clk,
    input  wire                                         rst,
    input  wire                                         chan_wr,
    input  wire  [dma_ctrl_pkg::chan_reg_width-1:0]     wr_reg,
    input  wire  [dma_ctrl_pkg::axil_data_width-1:0]    wr_data,
    input  wire                                         chan_rd,
    input  wire  [dma_ctrl_pkg::chan_reg_width-1:0]     rd_reg,
    output logic [dma_ctrl_pkg::axil_data_width-1:0]    rd_word,
    output logic [dma_ctrl_pkg::pcie_addr_width-1:0]    desc_pcie_addr,
    output logic [dma_ctrl_pkg::dma_axi_addr_width-1:0] desc_axi_addr,
    output logic [dma_ctrl_pkg::dma_len_width-1:0]      desc_len,
    output logic [dma_ctrl_pkg::dma_tag_width-1:0]      desc_tag,
    output logic                                        desc_valid,
    input  wire                                         desc_ready,
    input  wire  [dma_ctrl_pkg::dma_tag_width-1:0]      status_tag,
    input  wire                                         status_valid,
    output logic                                        status_ready
);
    import dma_ctrl_pkg::*;

    logic [4:0] wr_off;
    logic [4:0] rd_off;

    assign wr_off = {wr_reg, 2'b00};
    assign rd_off = {rd_reg, 2'b00};

    // descriptor fields reload on every write
    always_ff @(posedge clk) begin
        if (chan_wr) begin
            case (wr_off)
                chan_pcie_addr_lo:
                    desc_pcie_addr[axil_data_width-1:0] <= wr_data;
                chan_pcie_addr_hi:
                    desc_pcie_addr[pcie_addr_width-1:axil_data_width] <= wr_data;
                chan_axi_addr:
                    desc_axi_addr <= wr_data[dma_axi_addr_width-1:0];
                chan_len:
                    desc_len <= wr_data[dma_len_width-1:0];
                chan_tag_go:
                    desc_tag <= wr_data[dma_tag_width-1:0];
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            desc_valid   <= 1'b0;
            status_ready <= 1'b0;
        end else begin
            // tag write launches the descriptor
            if (chan_wr && wr_off == chan_tag_go)
                desc_valid <= 1'b1;
            else if (desc_ready)
                desc_valid <= 1'b0;
            // pop one status per status read
            status_ready <= chan_rd && status_valid;
        end
    end

    // tag is only shown while a status waits
    always_comb begin
        rd_word = '0;
        if (rd_off == chan_status && status_valid) begin
            rd_word[dma_tag_width-1:0] = status_tag;
            rd_word[status_valid_bit]  = 1'b1;
        end
    end

    // an offered descriptor holds until the engine takes it
    assert property (@(posedge clk) disable iff (rst)
        desc_valid && !desc_ready
        |=> $stable({desc_pcie_addr, desc_axi_addr, desc_len, desc_tag}));

endmodule

`default_nettype wire

/* tlp_counters.sv */
`default_nettype none

module tlp_counters (
    input  wire                                  clk,
    input  wire                                  rst,
    input  wire                                  rq_valid,
    input  wire                                  rq_ready,
    input  wire                                  rq_last,
    input  wire                                  rc_valid,
    input  wire                                  rc_ready,
    input  wire                                  rc_last,
    input  wire                                  cq_valid,
    input  wire                                  cq_ready,
    input  wire                                  cq_last,
    input  wire                                  cc_valid,
    input  wire                                  cc_ready,
    input  wire                                  cc_last,
    output logic [dma_ctrl_pkg::count_width-1:0] rq_count,
    output logic [dma_ctrl_pkg::count_width-1:0] rc_count,
    output logic [dma_ctrl_pkg::count_width-1:0] cq_count,
    output logic [dma_ctrl_pkg::count_width-1:0] cc_count
);

    // one step per completed frame, wraps silently
    always_ff @(posedge clk) begin
        if (rst) begin
            rq_count <= '0;
            rc_count <= '0;
            cq_count <= '0;
            cc_count <= '0;
        end else begin
            if (rq_valid && rq_ready && rq_last)
                rq_count <= rq_count + 1'b1;
            if (rc_valid && rc_ready && rc_last)
                rc_count <= rc_count + 1'b1;
            if (cq_valid && cq_ready && cq_last)
                cq_count <= cq_count + 1'b1;
            if (cc_valid && cc_ready && cc_last)
                cc_count <= cc_count + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* dma_ctrl_core.sv */
`default_nettype none

module dma_ctrl_core (
    input  wire                                         clk,
    input  wire                                         rst,
    input  wire  [dma_ctrl_pkg::axil_addr_width-1:0]    awaddr,
    input  wire                                         awvalid,
    output logic                                        awready,
    input  wire  [dma_ctrl_pkg::axil_data_width-1:0]    wdata,
    input  wire  [dma_ctrl_pkg::axil_data_width/8-1:0]  wstrb,
    input  wire                                         wvalid,
    output logic                                        wready,
    output logic [1:0]                                  bresp,
    output logic                                        bvalid,
    input  wire                                         bready,
    input  wire  [dma_ctrl_pkg::axil_addr_width-1:0]    araddr,
    input  wire                                         arvalid,
    output logic                                        arready,
    output logic [dma_ctrl_pkg::axil_data_width-1:0]    rdata,
    output logic [1:0]                                  rresp,
    output logic                                        rvalid,
    input  wire                                         rready,
    output logic [dma_ctrl_pkg::pcie_addr_width-1:0]    read_desc_pcie_addr,
    output logic [dma_ctrl_pkg::dma_axi_addr_width-1:0] read_desc_axi_addr,
    output logic [dma_ctrl_pkg::dma_len_width-1:0]      read_desc_len,
    output logic [dma_ctrl_pkg::dma_tag_width-1:0]      read_desc_tag,
    output logic                                        read_desc_valid,
    input  wire                                         read_desc_ready,
    input  wire  [dma_ctrl_pkg::dma_tag_width-1:0]      read_status_tag,
    input  wire                                         read_status_valid,
    output logic                                        read_status_ready,
    output logic [dma_ctrl_pkg::pcie_addr_width-1:0]    write_desc_pcie_addr,
    output logic [dma_ctrl_pkg::dma_axi_addr_width-1:0] write_desc_axi_addr,
    output logic [dma_ctrl_pkg::dma_len_width-1:0]      write_desc_len,
    output logic [dma_ctrl_pkg::dma_tag_width-1:0]      write_desc_tag,
    output logic                                        write_desc_valid,
    input  wire                                         write_desc_ready,
    input  wire  [dma_ctrl_pkg::dma_tag_width-1:0]      write_status_tag,
    input  wire                                         write_status_valid,
    output logic                                        write_status_ready,
    input  wire                                         rq_valid,
    input  wire                                         rq_ready,
    input  wire                                         rq_last,
    input  wire                                         rc_valid,
    input  wire                                         rc_ready,
    input  wire                                         rc_last,
    input  wire                                         cq_valid,
    input  wire                                         cq_ready,
    input  wire                                         cq_last,
    input  wire                                         cc_valid,
    input  wire                                         cc_ready,
    input  wire                                         cc_last,
    output logic                                        dma_enable,
    output logic                                        irq
);
    import dma_ctrl_pkg::*;

    logic                       wr_en;
    logic                       rd_en;
    logic [axil_addr_width-1:0] wr_addr;
    logic [axil_addr_width-1:0] rd_addr;
    logic [axil_data_width-1:0] wr_data;
    logic [axil_data_width-1:0] rd_data;
    logic                       read_chan_wr;
    logic                       write_chan_wr;
    logic                       read_chan_rd;
    logic                       write_chan_rd;
    logic [chan_reg_width-1:0]  wr_reg;
    logic [axil_data_width-1:0] read_rd_word;
    logic [axil_data_width-1:0] write_rd_word;
    logic [count_width-1:0]     rq_count;
    logic [count_width-1:0]     rc_count;
    logic [count_width-1:0]     cq_count;
    logic [count_width-1:0]     cc_count;

    axil_reg_port port0 (
        .clk, .rst,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .wr_en, .wr_addr, .wr_data, .rd_en, .rd_addr, .rd_data
    );

    ctrl_reg_map map0 (
        .clk, .rst,
        .wr_en, .wr_addr, .wr_data, .rd_en, .rd_addr, .rd_data,
        .read_chan_wr, .write_chan_wr, .read_chan_rd, .write_chan_rd, .wr_reg,
        .read_rd_word, .write_rd_word,
        .rq_count, .rc_count, .cq_count, .cc_count,
        .read_status_valid, .write_status_valid,
        .dma_enable, .irq
    );

    // channel register index taken straight from address bits 4:2
    dma_desc_regs read_chan (
        .clk, .rst,
        .chan_wr(read_chan_wr), .wr_reg, .wr_data,
        .chan_rd(read_chan_rd), .rd_reg(rd_addr[4:2]), .rd_word(read_rd_word),
        .desc_pcie_addr(read_desc_pcie_addr), .desc_axi_addr(read_desc_axi_addr),
        .desc_len(read_desc_len), .desc_tag(read_desc_tag),
        .desc_valid(read_desc_valid), .desc_ready(read_desc_ready),
        .status_tag(read_status_tag), .status_valid(read_status_valid),
        .status_ready(read_status_ready)
    );

    dma_desc_regs write_chan (
        .clk, .rst,
        .chan_wr(write_chan_wr), .wr_reg, .wr_data,
        .chan_rd(write_chan_rd), .rd_reg(rd_addr[4:2]), .rd_word(write_rd_word),
        .desc_pcie_addr(write_desc_pcie_addr), .desc_axi_addr(write_desc_axi_addr),
        .desc_len(write_desc_len), .desc_tag(write_desc_tag),
        .desc_valid(write_desc_valid), .desc_ready(write_desc_ready),
        .status_tag(write_status_tag), .status_valid(write_status_valid),
        .status_ready(write_status_ready)
    );

    tlp_counters counters0 (
        .clk, .rst,
        .rq_valid, .rq_ready, .rq_last,
        .rc_valid, .rc_ready, .rc_last,
        .cq_valid, .cq_ready, .cq_last,
        .cc_valid, .cc_ready, .cc_last,
        .rq_count, .rc_count, .cq_count, .cc_count
    );

endmodule

`default_nettype wire

/* dma_ctrl_tb.sv */
`default_nettype none

module dma_ctrl_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int num_ops    = 400;
    // eight setup writes come before the random operations
    localparam int max_cycles = 20 * (num_ops + 8) + 2000;

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    logic [31:0] awaddr = '0;
    logic        awvalid = 1'b0;
    logic [31:0] wdata = '0;
    logic [3:0]  wstrb = 4'hf;
    logic        wvalid = 1'b0;
    logic        bready = 1'b0;
    logic [31:0] araddr = '0;
    logic        arvalid = 1'b0;
    logic        rready = 1'b0;
    logic [1:0]  desc_ready = '0;
    logic [1:0]  stat_valid = '0;
    logic [7:0]  stat_tag [2] = '{8'h5a, 8'ha5};
    logic [11:0] tap = '0;

    wire        awready, wready, bvalid, arready, rvalid;
    wire [1:0]  bresp, rresp;
    wire [31:0] rdata;
    wire [63:0] read_desc_pcie_addr, write_desc_pcie_addr;
    wire [31:0] read_desc_axi_addr, write_desc_axi_addr;
    wire [15:0] read_desc_len, write_desc_len;
    wire [7:0]  read_desc_tag, write_desc_tag;
    wire        read_desc_valid, write_desc_valid;
    wire        read_status_ready, write_status_ready;
    wire        dma_enable, irq;

    // register and engine model
    logic [31:0] bus_state;
    logic [31:0] env_state;
    logic        m_enable = 1'b0;
    logic [63:0] m_pcie [2];
    logic [31:0] m_axi [2];
    logic [15:0] m_len [2];
    logic [7:0]  m_tag [2];
    logic [1:0]  pending = '0;
    logic [1:0]  pop_req = '0;
    logic [1:0]  pop_due = '0;
    int          owed [2] = '{0, 0};
    int          delay [2] = '{0, 0};
    logic [31:0] frames [4] = '{0, 0, 0, 0};
    int          cycles = 0;

    dma_ctrl_core dut0 (
        .clk, .rst,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .read_desc_pcie_addr, .read_desc_axi_addr, .read_desc_len, .read_desc_tag,
        .read_desc_valid, .read_desc_ready(desc_ready[0]),
        .read_status_tag(stat_tag[0]), .read_status_valid(stat_valid[0]),
        .read_status_ready,
        .write_desc_pcie_addr, .write_desc_axi_addr, .write_desc_len, .write_desc_tag,
        .write_desc_valid, .write_desc_ready(desc_ready[1]),
        .write_status_tag(stat_tag[1]), .write_status_valid(stat_valid[1]),
        .write_status_ready,
        .rq_valid(tap[0]), .rq_ready(tap[1]), .rq_last(tap[2]),
        .rc_valid(tap[3]), .rc_ready(tap[4]), .rc_last(tap[5]),
        .cq_valid(tap[6]), .cq_ready(tap[7]), .cq_last(tap[8]),
        .cc_valid(tap[9]), .cc_ready(tap[10]), .cc_last(tap[11]),
        .dma_enable, .irq
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // low LCG bits repeat quickly so only the upper half is used
    function automatic logic [15:0] bus_rand();
        bus_state = lcg_next(bus_state);
        return bus_state[31:16];
    endfunction

    function automatic logic [15:0] env_rand();
        env_state = lcg_next(env_state);
        return env_state[31:16];
    endfunction

    // 0 for the read channel block, 1 for the write channel block
    function automatic int chan_of(input logic [15:0] a);
        if (a[15:5] == 11'h008)
            return 0;
        if (a[15:5] == 11'h010)
            return 1;
        return -1;
    endfunction

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            $display("Result: FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
        logic [15:0] a;
        int          ch;
        logic        done;
        a  = {addr[15:2], 2'b00};
        ch = chan_of(a);
        // software waits until the engine has taken the offered descriptor
        while (ch >= 0 && pending[ch])
            @(negedge clk);
        @(posedge clk);
        awaddr  <= addr;
        wdata   <= data;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        @(negedge clk);
        @(negedge clk);
        check("awready", awready, 1'b1);
        check("wready", wready, 1'b1);
        check("bvalid", bvalid, 1'b1);
        check("bresp", bresp, 2'b00);
        done = bready;
        // the register took the write at the last edge
        if (a == 16'h0000) begin
            m_enable = data[0];
        end else if (ch >= 0) begin
            case (a[4:0])
                5'h00: m_pcie[ch][31:0] = data;
                5'h04: m_pcie[ch][63:32] = data;
                5'h08: m_axi[ch] = data;
                5'h10: m_len[ch] = data[15:0];
                5'h14: begin
                    m_tag[ch] = data[7:0];
                    pending[ch] = 1'b1;
                end
                default: ;
            endcase
        end
        @(posedge clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        while (!done) begin
            @(negedge clk);
            check("bvalid", bvalid, 1'b1);
            done = bready;
        end
    endtask

    task automatic bus_read(input logic [31:0] addr);
        logic [15:0] a;
        int          ch;
        logic [31:0] exp;
        logic        done;
        a  = {addr[15:2], 2'b00};
        ch = chan_of(a);
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        // the read word is taken from the state in the accept cycle
        @(negedge clk);
        exp = '0;
        if (a == 16'h0000) begin
            exp[0] = m_enable;
        end else if (ch >= 0 && a[4:0] == 5'h18) begin
            if (stat_valid[ch]) begin
                exp[31]  = 1'b1;
                exp[7:0] = stat_tag[ch];
            end
            pop_req[ch] = stat_valid[ch];
        end else if (a[15:4] == 12'h040) begin
            exp = frames[a[3:2]];
        end
        @(negedge clk);
        check("arready", arready, 1'b1);
        check("rvalid", rvalid, 1'b1);
        check("rdata", rdata, exp);
        check("rresp", rresp, 2'b00);
        done = rready;
        @(posedge clk);
        arvalid <= 1'b0;
        while (!done) begin
            @(negedge clk);
            check("rvalid", rvalid, 1'b1);
            done = rready;
        end
    endtask

    task automatic random_op();
        logic [15:0] r;
        logic [15:0] kind;
        logic [15:0] hi;
        logic [15:0] lo;
        logic [15:0] d_hi;
        r    = bus_rand();
        kind = bus_rand();
        hi   = bus_rand();
        d_hi = bus_rand();
        case (r[2:0])
            3'd0:       lo = 16'h0000;
            3'd1, 3'd2: lo = 16'h0100 | {r[5:3], 2'b00};
            3'd3, 3'd4: lo = 16'h0200 | {r[5:3], 2'b00};
            3'd5:       lo = 16'h0400 | {r[4:3], 2'b00};
            default:    lo = {5'b0, r[13:3]};
        endcase
        // byte lane bits and upper address bits play no part in decoding
        lo[1:0] = r[15:14];
        if (kind[15])
            bus_write({hi, lo}, {d_hi, kind});
        else
            bus_read({hi, lo});
    endtask

    task automatic engine_step(input int ch, input logic dv, input logic [63:0] pcie,
                               input logic [31:0] axi, input logic [15:0] len,
                               input logic [7:0] tag, input logic sready);
        string       pre;
        logic [15:0] r;
        pre = (ch == 0) ? "read_" : "write_";
        check({pre, "desc_valid"}, dv, pending[ch]);
        if (dv) begin
            check({pre, "desc_pcie_addr"}, pcie, m_pcie[ch]);
            check({pre, "desc_axi_addr"}, axi, m_axi[ch]);
            check({pre, "desc_len"}, len, m_len[ch]);
            check({pre, "desc_tag"}, tag, m_tag[ch]);
            if (desc_ready[ch]) begin
                pending[ch] = 1'b0;
                owed[ch]++;
            end
        end
        check({pre, "status_ready"}, sready, pop_due[ch]);
        pop_due[ch] = pop_req[ch];
        pop_req[ch] = 1'b0;
        if (delay[ch] > 0)
            delay[ch]--;
        r = env_rand();
        if (sready) begin
            // tag lines carry junk while no status waits
            stat_valid[ch] <= 1'b0;
            stat_tag[ch]   <= r[15:8];
            delay[ch]      = r[10:8];
        end else if (!stat_valid[ch] && owed[ch] > 0 && delay[ch] == 0) begin
            stat_valid[ch] <= 1'b1;
            stat_tag[ch]   <= r[7:0];
            owed[ch]--;
        end
        desc_ready[ch] <= r[13:12] != 2'b00;
    endtask

    // engine, stream taps and response back-pressure sampled before the edge
    always @(posedge clk) begin : env_model
        logic [15:0] r;
        if (!rst) begin
            check("irq", irq, stat_valid[0] | stat_valid[1]);
            check("dma_enable", dma_enable, m_enable);
            engine_step(0, read_desc_valid, read_desc_pcie_addr, read_desc_axi_addr,
                        read_desc_len, read_desc_tag, read_status_ready);
            engine_step(1, write_desc_valid, write_desc_pcie_addr, write_desc_axi_addr,
                        write_desc_len, write_desc_tag, write_status_ready);
            for (int i = 0; i < 4; i++) begin
                if (tap[3*i +: 3] == 3'b111)
                    frames[i] = frames[i] + 1;
            end
            r = env_rand();
            tap <= r[11:0];
            r = env_rand();
            bready <= r[1:0] != 2'b00;
            rready <= r[3:2] != 2'b00;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == max_cycles) begin
            $display("timeout: no end of test after %0d cycles", max_cycles);
            $display("Result: FAILED");
            $fatal(1, "timeout");
        end
    end

    initial begin
        logic [15:0] d_hi;
        logic [15:0] d_lo;
        bus_state = 32'd15561;
        env_state = ~32'd15561;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        // known descriptor fields in both channels
        for (int ch = 0; ch < 2; ch++) begin
            for (int off = 0; off <= 16; off += 4) begin
                if (off != 12) begin
                    d_hi = bus_rand();
                    d_lo = bus_rand();
                    bus_write(32'h100 * (ch + 1) + off, {d_hi, d_lo});
                end
            end
        end
        for (int n = 0; n < num_ops; n++)
            random_op();
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* dma_ctrl.f */
dma_ctrl_pkg.sv
axil_reg_port.sv
ctrl_reg_map.sv
dma_desc_regs.sv
tlp_counters.sv
dma_ctrl_core.sv
dma_ctrl_tb.sv

/* Bender.yml */
package:
  name: dma_ctrl

sources:
  - dma_ctrl_pkg.sv
  - axil_reg_port.sv
  - ctrl_reg_map.sv
  - dma_desc_regs.sv
  - tlp_counters.sv
  - dma_ctrl_core.sv
  - target: test
    files:
      - dma_ctrl_tb.sv
